/* include/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Register index and datapath widths
`define CORE_REG_ADDR_W 5
`define CORE_XLEN 32

// Trap unit constants
`define CORE_EXC_CAUSE_W 5
`define CORE_MEPC_RESET 32'h0000_0000

`endif

/* logic/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`CORE_XLEN-1:0]        xlen_t;
    typedef logic [`CORE_EXC_CAUSE_W-1:0] exc_cause_t;

    // mcause codes for synchronous exceptions
    localparam exc_cause_t EXC_CAUSE_INSTR_ADDR_MISAL = 5'd0;
    localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN     = 5'd2;

    // Operand source select for the ID stage
    typedef enum logic [2:0] {
        NO_FORWARD,
        FWD_EX_ALU_RES_TO_ID,
        FWD_MEM_ALU_RES_TO_ID,
        FWD_MEM_RDATA_TO_ID,
        FWD_WB_ALU_RES_TO_ID,
        FWD_WB_RDATA_TO_ID
    } forward_t;

    typedef enum logic [1:0] {
        PC_NEXT,
        PC_JAL,
        PC_JALR,
        PC_BRANCH
    } pc_source_t;

    // Decoded instruction as seen in ID
    typedef struct packed {
        logic       valid;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       alu_wen;
        logic       mem_wen;
        pc_source_t pc_source;
        logic       illegal;
        logic       misaligned;
        logic       is_mret;
        xlen_t      pc;
    } id_instr_t;

    // One slot of EX, MEM or WB
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      alu_wen;
        logic      mem_wen;
        xlen_t     pc;
    } stage_info_t;

endpackage

/* logic/stage_tracker.sv */
`timescale 1ns/10ps

module stage_tracker import core_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  id_instr_t   id_instr_i,
    input  logic        stall_ex_i,
    input  logic        flush_ex_i,
    input  logic        flush_mem_i,
    output stage_info_t ex_stage_o,
    output stage_info_t mem_stage_o,
    output stage_info_t wb_stage_o
);

    // Empty slot, nothing gets written back
    localparam stage_info_t BUBBLE = '0;

    stage_info_t id_slot;
    stage_info_t ex_q;
    stage_info_t mem_q;
    stage_info_t wb_q;

    // Only the writeback summary of the ID instruction moves on
    always_comb begin
        id_slot.valid   = id_instr_i.valid;
        id_slot.rd      = id_instr_i.rd;
        id_slot.alu_wen = id_instr_i.valid && id_instr_i.alu_wen;
        id_slot.mem_wen = id_instr_i.valid && id_instr_i.mem_wen;
        id_slot.pc      = id_instr_i.pc;
    end

    // EX slot holds while the FPU keeps EX busy
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ex_q <= BUBBLE;
        end else if (!stall_ex_i) begin
            if (flush_ex_i) begin
                ex_q <= BUBBLE;
            end else begin
                ex_q <= id_slot;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_q <= BUBBLE;
        end else if (flush_mem_i) begin
            mem_q <= BUBBLE;
        end else begin
            mem_q <= ex_q;
        end
    end

    // WB never stalls or flushes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_q <= BUBBLE;
        end else begin
            wb_q <= mem_q;
        end
    end

    assign ex_stage_o  = ex_q;
    assign mem_stage_o = mem_q;
    assign wb_stage_o  = wb_q;

endmodule

/* logic/controller.sv */
`timescale 1ns/10ps

module controller import core_pkg::*; (
    input  id_instr_t   id_instr_i,
    input  stage_info_t ex_stage_i,
    input  stage_info_t mem_stage_i,
    input  stage_info_t wb_stage_i,
    input  logic        branch_taken_ex_i,
    input  logic        misaligned_ex_i,
    input  logic        fpu_req_i,
    input  logic        fpu_gnt_i,
    input  logic        fpu_busy_i,
    output forward_t    fwd_op1_o,
    output forward_t    fwd_op2_o,
    output logic        stall_if_o,
    output logic        stall_id_o,
    output logic        stall_ex_o,
    output logic        flush_id_o,
    output logic        flush_ex_o,
    output logic        flush_mem_o,
    output logic        save_pc_id_o,
    output logic        save_pc_ex_o,
    output exc_cause_t  exception_cause_o
);

    logic trap_ex;
    logic trap_id;
    logic fpu_gnt_stall;
    logic load_use;
    logic id_is_jump;

    // Nearest producer wins, ALU result before load data
    function automatic forward_t resolve_fwd(
        input reg_addr_t   rs,
        input stage_info_t ex,
        input stage_info_t mem,
        input stage_info_t wb
    );
        forward_t sel;
        sel = NO_FORWARD;
        if (rs != '0) begin
            if (ex.valid && ex.alu_wen && ex.rd == rs) begin
                sel = FWD_EX_ALU_RES_TO_ID;
            end else if (mem.valid && mem.rd == rs && (mem.alu_wen || mem.mem_wen)) begin
                sel = mem.alu_wen ? FWD_MEM_ALU_RES_TO_ID : FWD_MEM_RDATA_TO_ID;
            end else if (wb.valid && wb.rd == rs && (wb.alu_wen || wb.mem_wen)) begin
                sel = wb.alu_wen ? FWD_WB_ALU_RES_TO_ID : FWD_WB_RDATA_TO_ID;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_op1_o = resolve_fwd(id_instr_i.rs1, ex_stage_i, mem_stage_i, wb_stage_i);
        fwd_op2_o = resolve_fwd(id_instr_i.rs2, ex_stage_i, mem_stage_i, wb_stage_i);
    end

    assign trap_ex = ex_stage_i.valid && misaligned_ex_i;
    assign trap_id = id_instr_i.valid &&
                     (id_instr_i.illegal || id_instr_i.misaligned || id_instr_i.is_mret);

    assign fpu_gnt_stall = fpu_req_i && !fpu_gnt_i;

    // Load data only exists after MEM, so a dependent op must wait a cycle
    assign load_use = ex_stage_i.valid && ex_stage_i.mem_wen &&
                      ((id_instr_i.rs1 != '0 && ex_stage_i.rd == id_instr_i.rs1) ||
                       (id_instr_i.rs2 != '0 && ex_stage_i.rd == id_instr_i.rs2));

    assign id_is_jump = (id_instr_i.pc_source == PC_JAL) || (id_instr_i.pc_source == PC_JALR);

    always_comb begin
        stall_ex_o = fpu_busy_i;
        stall_id_o = stall_ex_o || fpu_gnt_stall || load_use;
        stall_if_o = stall_id_o;
    end

    // Each flush pulls in every stage above it
    always_comb begin
        flush_mem_o = trap_ex || stall_ex_o;
        flush_ex_o  = flush_mem_o || branch_taken_ex_i || stall_id_o || trap_id;
        flush_id_o  = flush_ex_o || id_is_jump;
    end

    // EX trap is older, so it beats anything in ID
    always_comb begin
        save_pc_ex_o      = 1'b0;
        save_pc_id_o      = 1'b0;
        exception_cause_o = '0;
        if (trap_ex) begin
            save_pc_ex_o      = 1'b1;
            exception_cause_o = EXC_CAUSE_INSTR_ADDR_MISAL;
        end else if (trap_id && !branch_taken_ex_i && !id_instr_i.is_mret) begin
            save_pc_id_o = 1'b1;
            if (id_instr_i.illegal) begin
                exception_cause_o = EXC_CAUSE_ILLEGAL_INSN;
            end else if (id_instr_i.misaligned) begin
                exception_cause_o = EXC_CAUSE_INSTR_ADDR_MISAL;
            end
        end
    end

endmodule

/* logic/trap_csr.sv */
`timescale 1ns/10ps

`include "core_cfg.svh"

module trap_csr import core_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       save_pc_id_i,
    input  logic       save_pc_ex_i,
    input  xlen_t      id_pc_i,
    input  xlen_t      ex_pc_i,
    input  exc_cause_t cause_i,
    output xlen_t      mepc_o,
    output exc_cause_t mcause_o
);

    xlen_t      mepc_q;
    exc_cause_t mcause_q;

    // EX save has priority, the controller never raises both anyway
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mepc_q   <= `CORE_MEPC_RESET;
            mcause_q <= '0;
        end else if (save_pc_ex_i) begin
            mepc_q   <= ex_pc_i;
            mcause_q <= cause_i;
        end else if (save_pc_id_i) begin
            mepc_q   <= id_pc_i;
            mcause_q <= cause_i;
        end
    end

    assign mepc_o   = mepc_q;
    assign mcause_o = mcause_q;

endmodule

/* logic/pipeline_ctrl.sv */
`timescale 1ns/10ps

module pipeline_ctrl import core_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  id_instr_t  id_instr_i,
    input  logic       branch_taken_ex_i,
    input  logic       misaligned_ex_i,
    input  logic       fpu_req_i,
    input  logic       fpu_gnt_i,
    input  logic       fpu_busy_i,
    output forward_t   fwd_op1_o,
    output forward_t   fwd_op2_o,
    output logic       stall_if_o,
    output logic       stall_id_o,
    output logic       stall_ex_o,
    output logic       flush_id_o,
    output logic       flush_ex_o,
    output logic       flush_mem_o,
    output logic       trap_taken_o,
    output xlen_t      mepc_o,
    output exc_cause_t mcause_o
);

    stage_info_t ex_stage;
    stage_info_t mem_stage;
    stage_info_t wb_stage;
    logic        save_pc_id;
    logic        save_pc_ex;
    exc_cause_t  exception_cause;

    stage_tracker i_stage_tracker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .id_instr_i  (id_instr_i),
        .stall_ex_i  (stall_ex_o),
        .flush_ex_i  (flush_ex_o),
        .flush_mem_i (flush_mem_o),
        .ex_stage_o  (ex_stage),
        .mem_stage_o (mem_stage),
        .wb_stage_o  (wb_stage)
    );

    controller i_controller (
        .id_instr_i        (id_instr_i),
        .ex_stage_i        (ex_stage),
        .mem_stage_i       (mem_stage),
        .wb_stage_i        (wb_stage),
        .branch_taken_ex_i (branch_taken_ex_i),
        .misaligned_ex_i   (misaligned_ex_i),
        .fpu_req_i         (fpu_req_i),
        .fpu_gnt_i         (fpu_gnt_i),
        .fpu_busy_i        (fpu_busy_i),
        .fwd_op1_o         (fwd_op1_o),
        .fwd_op2_o         (fwd_op2_o),
        .stall_if_o        (stall_if_o),
        .stall_id_o        (stall_id_o),
        .stall_ex_o        (stall_ex_o),
        .flush_id_o        (flush_id_o),
        .flush_ex_o        (flush_ex_o),
        .flush_mem_o       (flush_mem_o),
        .save_pc_id_o      (save_pc_id),
        .save_pc_ex_o      (save_pc_ex),
        .exception_cause_o (exception_cause)
    );

    trap_csr i_trap_csr (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .save_pc_id_i (save_pc_id),
        .save_pc_ex_i (save_pc_ex),
        .id_pc_i      (id_instr_i.pc),
        .ex_pc_i      (ex_stage.pc),
        .cause_i      (exception_cause),
        .mepc_o       (mepc_o),
        .mcause_o     (mcause_o)
    );

    // Trap is visible in the same cycle as the save strobe
    assign trap_taken_o = save_pc_id || save_pc_ex;

endmodule

/* verif/pipeline_ctrl_chk.sv */
`timescale 1ns/10ps

module pipeline_ctrl_chk (
    input logic clk_i,
    input logic rst_i,
    input logic branch_taken_ex_i,
    input logic misaligned_ex_i,
    input logic stall_if_i,
    input logic stall_id_i,
    input logic stall_ex_i,
    input logic flush_id_i,
    input logic flush_ex_i,
    input logic flush_mem_i,
    input logic trap_taken_i
);

    stall_if_match: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_if_i == stall_id_i)
        else $error("stall_if differs from stall_id");

    // FPU busy freezes EX and drains MEM
    stall_ex_chain: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_ex_i |-> (stall_id_i && flush_mem_i))
        else $error("stall_ex without stall_id and flush_mem");

    flush_chain: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_ex_i |-> flush_id_i)
        else $error("flush_ex without flush_id");

    // Without an EX trap a taken branch cancels the ID trap
    no_trap_in_branch: assert property (@(posedge clk_i) disable iff (rst_i)
        (branch_taken_ex_i && !misaligned_ex_i) |-> !trap_taken_i)
        else $error("ID trap taken under a taken branch");

endmodule

bind pipeline_ctrl pipeline_ctrl_chk i_pipeline_ctrl_chk (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .misaligned_ex_i   (misaligned_ex_i),
    .stall_if_i        (stall_if_o),
    .stall_id_i        (stall_id_o),
    .stall_ex_i        (stall_ex_o),
    .flush_id_i        (flush_id_o),
    .flush_ex_i        (flush_ex_o),
    .flush_mem_i       (flush_mem_o),
    .trap_taken_i      (trap_taken_o)
);

/* verif/pipeline_ctrl_tb.sv */
`timescale 1ns/10ps

`include "core_cfg.svh"

module pipeline_ctrl_tb import core_pkg::*; ();

    localparam int HOLD_LIMIT = 8;
    localparam int GNT_DELAY  = 2;
    localparam stage_info_t EMPTY = '0;

    // EX side controls of a row act only on its first cycle
    typedef struct packed {
        id_instr_t id;
        logic      branch;
        logic      misal_ex;
        logic      fpu_busy;
        logic      fpu_req;
    } stim_t;

    logic       clk_i;
    logic       rst_i;
    id_instr_t  id_instr_i;
    logic       branch_taken_ex_i;
    logic       misaligned_ex_i;
    logic       fpu_req_i;
    logic       fpu_gnt_i;
    logic       fpu_busy_i;
    forward_t   fwd_op1_o;
    forward_t   fwd_op2_o;
    logic       stall_if_o;
    logic       stall_id_o;
    logic       stall_ex_o;
    logic       flush_id_o;
    logic       flush_ex_o;
    logic       flush_mem_o;
    logic       trap_taken_o;
    xlen_t      mepc_o;
    exc_cause_t mcause_o;

    // Model of the EX, MEM and WB slots plus the trap registers
    stage_info_t m_ex;
    stage_info_t m_mem;
    stage_info_t m_wb;
    xlen_t       exp_mepc;
    exc_cause_t  exp_mcause;
    stim_t       stim_q[$];
    string       name_q[$];
    int          checks;
    int          errors;
    int          timeouts;

    pipeline_ctrl i_pipeline_ctrl (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic void add_row(input string name, input string kind, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input reg_addr_t rd, input xlen_t pc,
                                    input logic [3:0] ctl);
        stim_t s;
        s                = '0;
        s.id.valid       = (kind != "idle");
        s.id.rs1         = rs1;
        s.id.rs2         = rs2;
        s.id.rd          = rd;
        s.id.alu_wen     = (kind == "alu") || (kind == "jal");
        s.id.mem_wen     = (kind == "load");
        s.id.pc_source   = (kind == "jal") ? PC_JAL : PC_NEXT;
        s.id.illegal     = (kind == "ill");
        s.id.misaligned  = (kind == "misal");
        s.id.is_mret     = (kind == "mret");
        s.id.pc          = pc;
        {s.branch, s.misal_ex, s.fpu_busy, s.fpu_req} = ctl;
        stim_q.push_back(s);
        name_q.push_back(name);
    endfunction

    // Walk from WB up to EX so the nearest producer overrides
    function automatic forward_t expect_fwd(input reg_addr_t rs);
        forward_t sel;
        sel = NO_FORWARD;
        if (rs != 5'd0) begin
            if (m_wb.valid && m_wb.rd == rs && m_wb.mem_wen)
                sel = FWD_WB_RDATA_TO_ID;
            if (m_wb.valid && m_wb.rd == rs && m_wb.alu_wen)
                sel = FWD_WB_ALU_RES_TO_ID;
            if (m_mem.valid && m_mem.rd == rs && m_mem.mem_wen)
                sel = FWD_MEM_RDATA_TO_ID;
            if (m_mem.valid && m_mem.rd == rs && m_mem.alu_wen)
                sel = FWD_MEM_ALU_RES_TO_ID;
            if (m_ex.valid && m_ex.rd == rs && m_ex.alu_wen)
                sel = FWD_EX_ALU_RES_TO_ID;
        end
        return sel;
    endfunction

    function automatic stage_info_t slot_of(input id_instr_t id);
        stage_info_t slot;
        slot.valid   = id.valid;
        slot.rd      = id.rd;
        slot.alu_wen = id.valid && id.alu_wen;
        slot.mem_wen = id.valid && id.mem_wen;
        slot.pc      = id.pc;
        return slot;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error %s %s: expected %0h, actual %0h", name, what, exp, act);
        end
    endtask

    // Drive one cycle, compare with the model, then advance the model
    task automatic apply_cycle(input string name, input stim_t s, input int n,
                               output logic stalled);
        logic trap_ex;
        logic trap_id;
        logic load_use;
        logic is_jump;
        logic exp_stall_id;
        logic exp_flush_mem;
        logic exp_flush_ex;
        logic exp_trap;
        id_instr_i        = s.id;
        branch_taken_ex_i = (n == 0) && s.branch;
        misaligned_ex_i   = (n == 0) && s.misal_ex;
        fpu_busy_i        = (n == 0) && s.fpu_busy;
        fpu_req_i         = s.fpu_req;
        fpu_gnt_i         = s.fpu_req && (n >= GNT_DELAY);
        trap_ex  = misaligned_ex_i && m_ex.valid;
        trap_id  = s.id.valid && (s.id.illegal || s.id.misaligned || s.id.is_mret);
        load_use = m_ex.valid && m_ex.mem_wen &&
                   ((s.id.rs1 != 5'd0 && s.id.rs1 == m_ex.rd) ||
                    (s.id.rs2 != 5'd0 && s.id.rs2 == m_ex.rd));
        is_jump  = (s.id.pc_source == PC_JAL) || (s.id.pc_source == PC_JALR);
        exp_stall_id  = fpu_busy_i || (fpu_req_i && !fpu_gnt_i) || load_use;
        exp_flush_mem = trap_ex || fpu_busy_i;
        exp_flush_ex  = exp_flush_mem || branch_taken_ex_i || exp_stall_id || trap_id;
        exp_trap      = trap_ex || (trap_id && !branch_taken_ex_i && !s.id.is_mret);
        #18;
        check_value(name, "fwd_op1", 32'(expect_fwd(s.id.rs1)), 32'(fwd_op1_o));
        check_value(name, "fwd_op2", 32'(expect_fwd(s.id.rs2)), 32'(fwd_op2_o));
        check_value(name, "stall_if", 32'(exp_stall_id), 32'(stall_if_o));
        check_value(name, "stall_id", 32'(exp_stall_id), 32'(stall_id_o));
        check_value(name, "stall_ex", 32'(fpu_busy_i), 32'(stall_ex_o));
        check_value(name, "flush_id", 32'(exp_flush_ex || is_jump), 32'(flush_id_o));
        check_value(name, "flush_ex", 32'(exp_flush_ex), 32'(flush_ex_o));
        check_value(name, "flush_mem", 32'(exp_flush_mem), 32'(flush_mem_o));
        check_value(name, "trap_taken", 32'(exp_trap), 32'(trap_taken_o));
        check_value(name, "mepc", exp_mepc, mepc_o);
        check_value(name, "mcause", 32'(exp_mcause), 32'(mcause_o));
        // The datapath holds ID for as long as the DUT asks
        stalled = stall_id_o;
        @(posedge clk_i);
        if (exp_trap) begin
            exp_mepc   = trap_ex ? m_ex.pc : s.id.pc;
            exp_mcause = (!trap_ex && s.id.illegal) ? EXC_CAUSE_ILLEGAL_INSN
                                                    : EXC_CAUSE_INSTR_ADDR_MISAL;
        end
        m_wb  = m_mem;
        m_mem = exp_flush_mem ? EMPTY : m_ex;
        if (!fpu_busy_i) begin
            m_ex = exp_flush_ex ? EMPTY : slot_of(s.id);
        end
        #2;
    endtask

    // ctl bits are branch, misaligned EX target, FPU busy, FPU request
    task automatic build_table();
        add_row("fwd_alu_x5", "alu", 5'd0, 5'd0, 5'd5, 32'h100, 4'b0000);
        add_row("fwd_alu_x6", "alu", 5'd0, 5'd0, 5'd6, 32'h104, 4'b0000);
        add_row("fwd_alu_x7", "alu", 5'd0, 5'd0, 5'd7, 32'h108, 4'b0000);
        add_row("fwd_ex_wb", "nop", 5'd7, 5'd5, 5'd0, 32'h10c, 4'b0000);
        add_row("fwd_mem_x0", "nop", 5'd0, 5'd7, 5'd0, 32'h110, 4'b0000);
        add_row("load_x9", "load", 5'd0, 5'd0, 5'd9, 32'h114, 4'b0000);
        add_row("load_use", "alu", 5'd9, 5'd0, 5'd10, 32'h118, 4'b0000);
        add_row("fpu_grant", "alu", 5'd10, 5'd9, 5'd11, 32'h11c, 4'b0001);
        add_row("fpu_busy", "nop", 5'd0, 5'd0, 5'd0, 32'h120, 4'b0010);
        add_row("branch_taken", "nop", 5'd0, 5'd0, 5'd0, 32'h124, 4'b1000);
        add_row("jal_in_id", "jal", 5'd0, 5'd0, 5'd1, 32'h128, 4'b0000);
        add_row("illegal_id", "ill", 5'd0, 5'd0, 5'd0, 32'h200, 4'b0000);
        add_row("misaligned_id", "misal", 5'd0, 5'd0, 5'd0, 32'h208, 4'b0000);
        add_row("ex_setup", "nop", 5'd0, 5'd0, 5'd0, 32'h300, 4'b0000);
        add_row("ex_misaligned", "ill", 5'd0, 5'd0, 5'd0, 32'h304, 4'b0100);
        add_row("mret_id", "mret", 5'd0, 5'd0, 5'd0, 32'h400, 4'b0000);
        add_row("trap_in_branch", "ill", 5'd0, 5'd0, 5'd0, 32'h404, 4'b1000);
        add_row("idle", "idle", 5'd0, 5'd0, 5'd0, 32'h0, 4'b0000);
    endtask

    initial begin
        logic stalled;
        int   n;
        rst_i             = 1'b1;
        id_instr_i        = '0;
        branch_taken_ex_i = 1'b0;
        misaligned_ex_i   = 1'b0;
        fpu_req_i         = 1'b0;
        fpu_gnt_i         = 1'b0;
        fpu_busy_i        = 1'b0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        m_ex       = EMPTY;
        m_mem      = EMPTY;
        m_wb       = EMPTY;
        exp_mepc   = `CORE_MEPC_RESET;
        exp_mcause = '0;
        build_table();
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        for (int r = 0; r < stim_q.size(); r++) begin
            // ID input holds while the DUT requests a stall
            stalled = 1'b1;
            n       = 0;
            while (stalled && n < HOLD_LIMIT) begin
                apply_cycle(name_q[r], stim_q[r], n, stalled);
                n++;
            end
            if (stalled) begin
                timeouts++;
                $display("Timeout: row %s kept ID stalled for %0d cycles", name_q[r], n);
            end
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
logic/core_pkg.sv
logic/stage_tracker.sv
logic/controller.sv
logic/trap_csr.sv
logic/pipeline_ctrl.sv
verif/pipeline_ctrl_chk.sv
verif/pipeline_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pipeline_ctrl_tb -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vpipeline_ctrl_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
